/* hw/soc_ctrl_defs.svh */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC control block constants
// bus and field widths, counts, reset values, word offsets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SOC_CTRL_DEFS_SVH
`define SOC_CTRL_DEFS_SVH

`define SOC_ADDR_W         12             // 4KB APB window
`define SOC_NB_PADS        32
`define SOC_PADCFG_W       6              // pu, pd, st, slew, drive[1:0]
`define SOC_JTAG_W         8
`define SOC_NB_CORES       16'd4
`define SOC_NB_CLUSTERS    16'd1
`define SOC_FC_BOOT_RST    32'h1A00_0080

// word offsets taken from PADDR[8:2]
`define SOC_REG_INFO       7'd0
`define SOC_REG_FCBOOT     7'd1
`define SOC_REG_FCFETCH    7'd2
`define SOC_REG_PADFUN0    7'd4
`define SOC_NB_PADFUN      7'd2           // words in the pad function group
`define SOC_REG_PADCFG0    7'd8
`define SOC_NB_PADCFG      7'd8           // words in the pad config group
`define SOC_REG_JTAG       7'd29
`define SOC_REG_CORESTATUS 7'd40
`define SOC_REG_CS_RO      7'd48
`define SOC_REG_BOOTSEL    7'd49
`define SOC_REG_CLKSEL     7'd50

`endif

/* hw/soc_ctrl_pkg.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC control package
// register word union shared by the decoder and pad registers
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package soc_ctrl_pkg;

   // one APB data word, read either as pad function or pad config fields
   typedef union packed
   {
      logic [31:0]      raw;   // plain bus word
      logic [15:0][1:0] fun;   // 16 pad function selects
      logic [3:0][7:0]  cfg;   // 4 pad config bytes
   } reg_word_u;

endpackage

`default_nettype wire

/* hw/apb_reg_decode.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave decode for the SoC control block
// word offset decode, group write strobes, read data mux
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defs.svh"

module apb_reg_decode (
   input  wire logic [`SOC_ADDR_W-1:0] PADDR_i,
   input  wire logic [31:0]            PWDATA_i,
   input  wire logic                   PWRITE_i,
   input  wire logic                   PSEL_i,
   input  wire logic                   PENABLE_i,
   output logic      [31:0]            PRDATA_o,
   output logic                        PREADY_o,
   output logic                        PSLVERR_o,
   input  wire soc_ctrl_pkg::reg_word_u pad_fun_rdata_i,
   input  wire soc_ctrl_pkg::reg_word_u pad_cfg_rdata_i,
   input  wire logic [31:0]            fc_bootaddr_i,
   input  wire logic                   fc_fetchen_i,
   input  wire logic [31:0]            corestatus_i,
   input  wire logic [1:0]             bootsel_i,
   input  wire logic                   clksel_i,
   input  wire logic [`SOC_JTAG_W-1:0] jtag_out_i,
   input  wire logic [`SOC_JTAG_W-1:0] jtag_in_sync_i,
   output soc_ctrl_pkg::reg_word_u     wdata_o,
   output logic      [2:0]             pad_idx_o,
   output logic                        pad_fun_we_o,
   output logic                        pad_cfg_we_o,
   output logic                        fcboot_we_o,
   output logic                        fcfetch_we_o,
   output logic                        corestatus_we_o,
   output logic                        jtag_we_o
);

   logic [6:0] reg_off;
   logic       apb_write;
   logic       sel_padfun;
   logic       sel_padcfg;

   assign reg_off    = PADDR_i[8:2];
   assign apb_write  = PSEL_i & PENABLE_i & PWRITE_i;   // commit edge of the access phase
   assign sel_padfun = (reg_off >= `SOC_REG_PADFUN0) &&
                       (reg_off < (`SOC_REG_PADFUN0 + `SOC_NB_PADFUN));
   assign sel_padcfg = (reg_off >= `SOC_REG_PADCFG0) &&
                       (reg_off < (`SOC_REG_PADCFG0 + `SOC_NB_PADCFG));

   // word index local to the selected pad group
   assign pad_idx_o = sel_padfun ? 3'(reg_off - `SOC_REG_PADFUN0)
                                 : 3'(reg_off - `SOC_REG_PADCFG0);

   assign wdata_o         = PWDATA_i;
   assign pad_fun_we_o    = apb_write & sel_padfun;
   assign pad_cfg_we_o    = apb_write & sel_padcfg;
   assign fcboot_we_o     = apb_write & (reg_off == `SOC_REG_FCBOOT);
   assign fcfetch_we_o    = apb_write & (reg_off == `SOC_REG_FCFETCH);
   assign corestatus_we_o = apb_write & (reg_off == `SOC_REG_CORESTATUS);
   assign jtag_we_o       = apb_write & (reg_off == `SOC_REG_JTAG);

   assign PREADY_o  = 1'b1;   // zero wait states
   assign PSLVERR_o = 1'b0;

   always_comb
   begin
      PRDATA_o = '0;   // unmapped offsets read 0
      if (sel_padfun)
         PRDATA_o = pad_fun_rdata_i.raw;
      else if (sel_padcfg)
         PRDATA_o = pad_cfg_rdata_i.raw;
      else
      begin
         case (reg_off)
            `SOC_REG_INFO:       PRDATA_o = {`SOC_NB_CORES, `SOC_NB_CLUSTERS};
            `SOC_REG_FCBOOT:     PRDATA_o = fc_bootaddr_i;
            `SOC_REG_FCFETCH:    PRDATA_o = {31'h0, fc_fetchen_i};
            `SOC_REG_JTAG:       PRDATA_o = {{(32-2*`SOC_JTAG_W){1'b0}}, jtag_in_sync_i,
                                             jtag_out_i};
            `SOC_REG_CORESTATUS: PRDATA_o = corestatus_i;
            `SOC_REG_CS_RO:      PRDATA_o = corestatus_i;   // read-only mirror
            `SOC_REG_BOOTSEL:    PRDATA_o = {30'h0, bootsel_i};
            `SOC_REG_CLKSEL:     PRDATA_o = {31'h0, clksel_i};
            default:             PRDATA_o = '0;
         endcase
      end
   end

   // a committed write lands in exactly one register group
   always_comb
   begin
      assert ($onehot0({pad_fun_we_o, pad_cfg_we_o, fcboot_we_o, fcfetch_we_o,
                        corestatus_we_o, jtag_we_o}))
         else $error("more than one write strobe active");
   end

endmodule

`default_nettype wire

/* hw/pad_ctrl_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pad function select and pad configuration registers
// storage for 32 pads and the packed read words
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defs.svh"

module pad_ctrl_regs (
   input  wire logic                    HCLK,
   input  wire logic                    HRESETn,
   input  wire logic [2:0]              pad_idx_i,
   input  wire logic                    pad_fun_we_i,
   input  wire logic                    pad_cfg_we_i,
   input  wire soc_ctrl_pkg::reg_word_u wdata_i,
   output logic [`SOC_NB_PADS-1:0][1:0]               pad_mux_o,
   output logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0] pad_cfg_o,
   output soc_ctrl_pkg::reg_word_u      pad_fun_rdata_o,
   output soc_ctrl_pkg::reg_word_u      pad_cfg_rdata_o
);

   // one function word covers 16 pads, one config word covers 4
   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         pad_mux_o <= '0;   // default pad function
         pad_cfg_o <= '1;
      end
      else
      begin
         for (int p = 0; p < `SOC_NB_PADS; p++)
         begin
            if (pad_fun_we_i && (3'(p / 16) == pad_idx_i))
               pad_mux_o[p] <= wdata_i.fun[p % 16];
            if (pad_cfg_we_i && (3'(p / 4) == pad_idx_i))
               pad_cfg_o[p] <= wdata_i.cfg[p % 4][`SOC_PADCFG_W-1:0];   // full 6-bit field
         end
      end
   end

   always_comb
   begin
      pad_fun_rdata_o = '0;
      pad_cfg_rdata_o = '0;   // spare byte bits stay 0
      for (int p = 0; p < `SOC_NB_PADS; p++)
      begin
         if (3'(p / 16) == pad_idx_i)
            pad_fun_rdata_o.fun[p % 16] = pad_mux_o[p];
         if (3'(p / 4) == pad_idx_i)
            pad_cfg_rdata_o.cfg[p % 4][`SOC_PADCFG_W-1:0] = pad_cfg_o[p];
      end
   end

   // decoder must keep function writes inside the two existing words
   a_padfun_idx : assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      pad_fun_we_i |-> (pad_idx_i < 3'd2)
   ) else $error("pad function write with index %0d", pad_idx_i);

endmodule

`default_nettype wire

/* hw/boot_ctrl_regs.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// boot control registers
// boot address, fetch enable, core status, boot-select sample
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defs.svh"

module boot_ctrl_regs (
   input  wire logic                    HCLK,
   input  wire logic                    HRESETn,
   input  wire logic                    fcboot_we_i,
   input  wire logic                    fcfetch_we_i,
   input  wire logic                    corestatus_we_i,
   input  wire soc_ctrl_pkg::reg_word_u wdata_i,
   input  wire logic                    fc_fetch_en_valid_i,
   input  wire logic                    fc_fetch_en_i,
   input  wire logic [1:0]              bootsel_i,
   input  wire logic                    sel_clk_i,
   output logic      [31:0]             fc_bootaddr_o,
   output logic                         fc_fetchen_o,
   output logic      [31:0]             corestatus_o,
   output logic      [1:0]              bootsel_o,
   output logic                         clksel_o
);

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         fc_bootaddr_o <= `SOC_FC_BOOT_RST;
         fc_fetchen_o  <= 1'b0;   // fabric controller held off after reset
         corestatus_o  <= '0;
         bootsel_o     <= 2'b00;
      end
      else
      begin
         bootsel_o <= bootsel_i;   // one sample stage on the pins

         if (fcboot_we_i)
            fc_bootaddr_o <= wdata_i.raw;

         // APB write beats the external strobe on the same edge
         if (fcfetch_we_i)
            fc_fetchen_o <= wdata_i.raw[0];
         else if (fc_fetch_en_valid_i)
            fc_fetchen_o <= fc_fetch_en_i;

         if (corestatus_we_i)
            corestatus_o <= wdata_i.raw;   // EOC in bit 31
      end
   end

   assign clksel_o = sel_clk_i;   // read live, no sampling

   a_fetchen_known : assert property (
      @(posedge HCLK) disable iff (!HRESETn)
      !$isunknown(fc_fetchen_o)
   ) else $error("fetch enable is unknown");

endmodule

`default_nettype wire

/* hw/jtag_mailbox.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// JTAG mailbox
// outgoing register and two-flop synchronizer on the input
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defs.svh"

module jtag_mailbox (
   input  wire logic                    HCLK,
   input  wire logic                    HRESETn,
   input  wire logic                    jtag_we_i,
   input  wire soc_ctrl_pkg::reg_word_u wdata_i,
   input  wire logic [`SOC_JTAG_W-1:0]  soc_jtag_reg_i,
   output logic      [`SOC_JTAG_W-1:0]  soc_jtag_reg_o,
   output logic      [`SOC_JTAG_W-1:0]  jtag_in_sync_o
);

   logic [`SOC_JTAG_W-1:0] jtag_meta_q;   // first sync stage

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         soc_jtag_reg_o <= '0;
         jtag_meta_q    <= '0;
         jtag_in_sync_o <= '0;
      end
      else
      begin
         jtag_meta_q    <= soc_jtag_reg_i;   // comes from the TCK domain
         jtag_in_sync_o <= jtag_meta_q;
         if (jtag_we_i)
            soc_jtag_reg_o <= wdata_i.raw[`SOC_JTAG_W-1:0];
      end
   end

endmodule

`default_nettype wire

/* hw/soc_ctrl_top.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SoC control register block top level
// APB decoder plus pad, boot and JTAG register groups
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defs.svh"

module soc_ctrl_top (
   input  wire logic                   HCLK,
   input  wire logic                   HRESETn,
   input  wire logic [`SOC_ADDR_W-1:0] PADDR_i,
   input  wire logic [31:0]            PWDATA_i,
   input  wire logic                   PWRITE_i,
   input  wire logic                   PSEL_i,
   input  wire logic                   PENABLE_i,
   output logic      [31:0]            PRDATA_o,
   output logic                        PREADY_o,
   output logic                        PSLVERR_o,
   input  wire logic                   sel_clk_i,
   input  wire logic [1:0]             bootsel_i,
   input  wire logic                   fc_fetch_en_valid_i,
   input  wire logic                   fc_fetch_en_i,
   input  wire logic [`SOC_JTAG_W-1:0] soc_jtag_reg_i,
   output logic      [`SOC_JTAG_W-1:0] soc_jtag_reg_o,
   output logic      [31:0]            fc_bootaddr_o,
   output logic                        fc_fetchen_o,
   output logic [`SOC_NB_PADS-1:0][1:0]               pad_mux_o,
   output logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0] pad_cfg_o
);

   soc_ctrl_pkg::reg_word_u wdata;
   soc_ctrl_pkg::reg_word_u pad_fun_rdata;
   soc_ctrl_pkg::reg_word_u pad_cfg_rdata;
   logic [2:0]              pad_idx;
   logic                    pad_fun_we;
   logic                    pad_cfg_we;
   logic                    fcboot_we;
   logic                    fcfetch_we;
   logic                    corestatus_we;
   logic                    jtag_we;
   logic [31:0]             corestatus;
   logic [1:0]              bootsel;
   logic                    clksel;
   logic [`SOC_JTAG_W-1:0]  jtag_in_sync;

   apb_reg_decode u_decode (
      .PADDR_i         (PADDR_i),
      .PWDATA_i        (PWDATA_i),
      .PWRITE_i        (PWRITE_i),
      .PSEL_i          (PSEL_i),
      .PENABLE_i       (PENABLE_i),
      .PRDATA_o        (PRDATA_o),
      .PREADY_o        (PREADY_o),
      .PSLVERR_o       (PSLVERR_o),
      .pad_fun_rdata_i (pad_fun_rdata),
      .pad_cfg_rdata_i (pad_cfg_rdata),
      .fc_bootaddr_i   (fc_bootaddr_o),
      .fc_fetchen_i    (fc_fetchen_o),
      .corestatus_i    (corestatus),
      .bootsel_i       (bootsel),
      .clksel_i        (clksel),
      .jtag_out_i      (soc_jtag_reg_o),
      .jtag_in_sync_i  (jtag_in_sync),
      .wdata_o         (wdata),
      .pad_idx_o       (pad_idx),
      .pad_fun_we_o    (pad_fun_we),
      .pad_cfg_we_o    (pad_cfg_we),
      .fcboot_we_o     (fcboot_we),
      .fcfetch_we_o    (fcfetch_we),
      .corestatus_we_o (corestatus_we),
      .jtag_we_o       (jtag_we)
   );

   pad_ctrl_regs u_pad (
      .HCLK            (HCLK),
      .HRESETn         (HRESETn),
      .pad_idx_i       (pad_idx),
      .pad_fun_we_i    (pad_fun_we),
      .pad_cfg_we_i    (pad_cfg_we),
      .wdata_i         (wdata),
      .pad_mux_o       (pad_mux_o),
      .pad_cfg_o       (pad_cfg_o),
      .pad_fun_rdata_o (pad_fun_rdata),
      .pad_cfg_rdata_o (pad_cfg_rdata)
   );

   boot_ctrl_regs u_boot (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .fcboot_we_i         (fcboot_we),
      .fcfetch_we_i        (fcfetch_we),
      .corestatus_we_i     (corestatus_we),
      .wdata_i             (wdata),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .bootsel_i           (bootsel_i),
      .sel_clk_i           (sel_clk_i),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .corestatus_o        (corestatus),
      .bootsel_o           (bootsel),
      .clksel_o            (clksel)
   );

   jtag_mailbox u_jtag (
      .HCLK           (HCLK),
      .HRESETn        (HRESETn),
      .jtag_we_i      (jtag_we),
      .wdata_i        (wdata),
      .soc_jtag_reg_i (soc_jtag_reg_i),
      .soc_jtag_reg_o (soc_jtag_reg_o),
      .jtag_in_sync_o (jtag_in_sync)
   );

endmodule

`default_nettype wire

/* dv/tb_soc_ctrl.sv */
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the SoC control register block
// APB read/write tasks, LFSR data, value checker, six tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "soc_ctrl_defs.svh"

module tb_soc_ctrl;

   localparam int TIMEOUT = 20;   // cycles allowed per wait

   logic                                      HCLK;
   logic                                      HRESETn;
   logic [`SOC_ADDR_W-1:0]                    PADDR_i;
   logic [31:0]                               PWDATA_i;
   logic                                      PWRITE_i;
   logic                                      PSEL_i;
   logic                                      PENABLE_i;
   logic [31:0]                               PRDATA_o;
   logic                                      PREADY_o;
   logic                                      PSLVERR_o;
   logic                                      sel_clk_i;
   logic [1:0]                                bootsel_i;
   logic                                      fc_fetch_en_valid_i;
   logic                                      fc_fetch_en_i;
   logic [`SOC_JTAG_W-1:0]                    soc_jtag_reg_i;
   logic [`SOC_JTAG_W-1:0]                    soc_jtag_reg_o;
   logic [31:0]                               fc_bootaddr_o;
   logic                                      fc_fetchen_o;
   logic [`SOC_NB_PADS-1:0][1:0]               pad_mux;
   logic [`SOC_NB_PADS-1:0][`SOC_PADCFG_W-1:0] pad_cfg;

   logic [31:0] lfsr;
   int          errors;
   string       test_name;
   logic [31:0] pf [2];   // expected pad function words
   logic [31:0] pc [8];   // expected pad config words, already masked
   logic [31:0] exp_fcboot;
   logic [31:0] exp_cs;
   logic        exp_fetch;
   logic [7:0]  exp_jtag_out;
   logic [7:0]  exp_jtag_in;

   soc_ctrl_top u_soc_ctrl_top (
      .HCLK                (HCLK),
      .HRESETn             (HRESETn),
      .PADDR_i             (PADDR_i),
      .PWDATA_i            (PWDATA_i),
      .PWRITE_i            (PWRITE_i),
      .PSEL_i              (PSEL_i),
      .PENABLE_i           (PENABLE_i),
      .PRDATA_o            (PRDATA_o),
      .PREADY_o            (PREADY_o),
      .PSLVERR_o           (PSLVERR_o),
      .sel_clk_i           (sel_clk_i),
      .bootsel_i           (bootsel_i),
      .fc_fetch_en_valid_i (fc_fetch_en_valid_i),
      .fc_fetch_en_i       (fc_fetch_en_i),
      .soc_jtag_reg_i      (soc_jtag_reg_i),
      .soc_jtag_reg_o      (soc_jtag_reg_o),
      .fc_bootaddr_o       (fc_bootaddr_o),
      .fc_fetchen_o        (fc_fetchen_o),
      .pad_mux_o           (pad_mux),
      .pad_cfg_o           (pad_cfg)
   );

   always #5 HCLK = ~HCLK;   // 100 MHz

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // one LFSR step per bit taken
   task automatic rand_word(output logic [31:0] w);
      for (int b = 0; b < 32; b++)
      begin
         lfsr = lfsr_step(lfsr);
         w[b] = lfsr[0];
      end
   endtask

   function automatic logic [`SOC_ADDR_W-1:0] reg_addr(input logic [6:0] off);
      reg_addr = {3'b000, off, 2'b00};
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_equal(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected)
      begin
         errors++;
         $display("ERR %s %s expected %08h actual %08h", test_name, what, expected, actual);
         $display("Simulation failed");
         $fatal(1);
      end
   endtask

   task automatic apb_setup(input logic [6:0] off, input logic [31:0] data, input logic wr);
      @(posedge HCLK);
      PADDR_i   <= reg_addr(off);
      PWDATA_i  <= data;
      PWRITE_i  <= wr;
      PSEL_i    <= 1'b1;
      PENABLE_i <= 1'b0;
   endtask

   task automatic wait_ready;
      int n;
      n = 0;
      @(negedge HCLK);
      while ((PREADY_o !== 1'b1) && (n < TIMEOUT))
      begin
         n++;
         @(negedge HCLK);
      end
      if (PREADY_o !== 1'b1)
         fail_run("PREADY stayed low past the timeout");
      check_equal("PSLVERR_o", 32'h0, {31'h0, PSLVERR_o});   // no error response
   endtask

   task automatic apb_finish;
      @(posedge HCLK);   // commit edge
      PSEL_i    <= 1'b0;
      PENABLE_i <= 1'b0;
      PWRITE_i  <= 1'b0;
   endtask

   task automatic apb_write(input logic [6:0] off, input logic [31:0] data);
      apb_setup(off, data, 1'b1);
      @(posedge HCLK);
      PENABLE_i <= 1'b1;
      wait_ready();
      apb_finish();
   endtask

   task automatic apb_read(input logic [6:0] off, output logic [31:0] data);
      apb_setup(off, 32'h0, 1'b0);
      @(posedge HCLK);
      PENABLE_i <= 1'b1;
      wait_ready();
      data = PRDATA_o;   // stable mid-cycle
      apb_finish();
   endtask

   // repeat a read until the masked value shows up or time runs out
   task automatic poll_read(input logic [6:0] off, input logic [31:0] mask,
                            input logic [31:0] expected, input string what);
      logic [31:0] d;
      int          n;
      n = 0;
      apb_read(off, d);
      while (((d & mask) !== expected) && (n < TIMEOUT))
      begin
         n++;
         apb_read(off, d);
      end
      check_equal(what, expected, d & mask);
   endtask

   task automatic check_pads;
      for (int p = 0; p < `SOC_NB_PADS; p++)
      begin
         check_equal("pad_mux_o", {30'h0, pf[p / 16][(p % 16) * 2 +: 2]}, {30'h0, pad_mux[p]});
         check_equal("pad_cfg_o", {26'h0, pc[p / 4][(p % 4) * 8 +: 6]}, {26'h0, pad_cfg[p]});
      end
   endtask

   // every mapped register and output against the model
   task automatic verify_all_regs;
      logic [31:0] d;
      @(negedge HCLK);
      check_equal("fc_bootaddr_o", exp_fcboot, fc_bootaddr_o);
      check_equal("fc_fetchen_o", {31'h0, exp_fetch}, {31'h0, fc_fetchen_o});
      check_equal("soc_jtag_reg_o", {24'h0, exp_jtag_out}, {24'h0, soc_jtag_reg_o});
      check_pads();
      apb_read(`SOC_REG_FCBOOT, d);
      check_equal("FCBOOT", exp_fcboot, d);
      apb_read(`SOC_REG_FCFETCH, d);
      check_equal("FCFETCH", {31'h0, exp_fetch}, d);
      for (int i = 0; i < 2; i++)
      begin
         apb_read(`SOC_REG_PADFUN0 + 7'(i), d);
         check_equal("PADFUN", pf[i], d);
      end
      for (int i = 0; i < 8; i++)
      begin
         apb_read(`SOC_REG_PADCFG0 + 7'(i), d);
         check_equal("PADCFG", pc[i], d);
      end
      apb_read(`SOC_REG_JTAG, d);
      check_equal("JTAG", {16'h0, exp_jtag_in, exp_jtag_out}, d);
      apb_read(`SOC_REG_CORESTATUS, d);
      check_equal("CORESTATUS", exp_cs, d);
      apb_read(`SOC_REG_CS_RO, d);
      check_equal("CS_RO", exp_cs, d);
   endtask

   task automatic test_reset_state;
      logic [31:0] d;
      test_name = "reset_state";
      apb_read(`SOC_REG_INFO, d);
      check_equal("INFO", 32'h0004_0001, d);   // 4 cores, 1 cluster
      verify_all_regs();
   endtask

   task automatic test_pad_function;
      logic [31:0] w;
      test_name = "pad_function";
      for (int i = 0; i < 2; i++)
      begin
         rand_word(w);
         pf[i] = w;
         apb_write(`SOC_REG_PADFUN0 + 7'(i), w);
      end
      verify_all_regs();
   endtask

   task automatic test_pad_config;
      logic [31:0] w;
      test_name = "pad_config";
      for (int i = 0; i < 8; i++)
      begin
         rand_word(w);
         pc[i] = w & 32'h3F3F_3F3F;   // 6 bits kept per byte
         apb_write(`SOC_REG_PADCFG0 + 7'(i), w);
      end
      verify_all_regs();
   endtask

   task automatic test_boot_fetch;
      logic [31:0] w;
      test_name = "boot_fetch";
      rand_word(w);
      exp_fcboot = w;
      apb_write(`SOC_REG_FCBOOT, w);
      apb_write(`SOC_REG_FCFETCH, 32'h1);
      @(negedge HCLK);
      check_equal("fetch after APB set", 32'h1, {31'h0, fc_fetchen_o});
      apb_write(`SOC_REG_FCFETCH, 32'hFFFF_FFFE);   // only bit 0 counts
      @(negedge HCLK);
      check_equal("fetch after APB clear", 32'h0, {31'h0, fc_fetchen_o});
      @(posedge HCLK);
      fc_fetch_en_valid_i <= 1'b1;
      fc_fetch_en_i       <= 1'b1;
      @(posedge HCLK);
      fc_fetch_en_valid_i <= 1'b0;
      @(negedge HCLK);
      check_equal("fetch after strobe", 32'h1, {31'h0, fc_fetchen_o});
      // strobe and APB write on the same commit edge
      apb_setup(`SOC_REG_FCFETCH, 32'h0, 1'b1);
      @(posedge HCLK);
      PENABLE_i           <= 1'b1;
      fc_fetch_en_valid_i <= 1'b1;
      fc_fetch_en_i       <= 1'b1;
      wait_ready();
      apb_finish();
      fc_fetch_en_valid_i <= 1'b0;
      fc_fetch_en_i       <= 1'b0;
      exp_fetch = 1'b0;
      verify_all_regs();
   endtask

   task automatic test_status;
      logic [31:0] w;
      logic [31:0] d;
      test_name = "status";
      rand_word(w);
      exp_cs = w;
      apb_write(`SOC_REG_CORESTATUS, w);
      apb_write(`SOC_REG_CS_RO, ~w);   // mirror ignores writes
      verify_all_regs();
      @(posedge HCLK);
      bootsel_i <= 2'b10;
      poll_read(`SOC_REG_BOOTSEL, 32'hFFFF_FFFF, 32'h2, "BOOTSEL");
      @(posedge HCLK);
      bootsel_i <= 2'b01;
      poll_read(`SOC_REG_BOOTSEL, 32'hFFFF_FFFF, 32'h1, "BOOTSEL");
      @(posedge HCLK);
      sel_clk_i <= 1'b1;
      apb_read(`SOC_REG_CLKSEL, d);
      check_equal("CLKSEL high", 32'h1, d);
      @(posedge HCLK);
      sel_clk_i <= 1'b0;
      apb_read(`SOC_REG_CLKSEL, d);
      check_equal("CLKSEL low", 32'h0, d);
   endtask

   task automatic test_jtag_unmapped;
      logic [31:0] w;
      logic [31:0] d;
      test_name = "jtag_unmapped";
      rand_word(w);
      exp_jtag_out = w[7:0];
      apb_write(`SOC_REG_JTAG, w);
      rand_word(w);
      exp_jtag_in = w[7:0];
      @(posedge HCLK);
      soc_jtag_reg_i <= w[7:0];
      poll_read(`SOC_REG_JTAG, 32'h0000_FF00, {16'h0, w[7:0], 8'h0}, "JTAG in");
      apb_read(7'd3, d);
      check_equal("offset 3", 32'h0, d);
      rand_word(w);
      apb_write(7'd3, w);
      apb_read(7'd3, d);
      check_equal("offset 3 after write", 32'h0, d);
      verify_all_regs();
   endtask

   initial
   begin
      HCLK                = 1'b0;
      HRESETn             = 1'b0;
      PADDR_i             = '0;
      PWDATA_i            = '0;
      PWRITE_i            = 1'b0;
      PSEL_i              = 1'b0;
      PENABLE_i           = 1'b0;
      sel_clk_i           = 1'b0;
      bootsel_i           = 2'b00;
      fc_fetch_en_valid_i = 1'b0;
      fc_fetch_en_i       = 1'b0;
      soc_jtag_reg_i      = '0;
      lfsr                = 32'hbb87;
      errors              = 0;
      pf                  = '{default: 32'h0};
      pc                  = '{default: 32'h3F3F_3F3F};
      exp_fcboot          = 32'h1A00_0080;
      exp_cs              = 32'h0;
      exp_fetch           = 1'b0;
      exp_jtag_out        = 8'h00;
      exp_jtag_in         = 8'h00;
      repeat (4) @(posedge HCLK);
      HRESETn <= 1'b1;
      test_reset_state();
      test_pad_function();
      test_pad_config();
      test_boot_fetch();
      test_status();
      test_jtag_unmapped();
      @(negedge HCLK);
      if (errors == 0)
      begin
         $display("Simulation completed successfully");
         $finish;
      end
      else
      begin
         $display("Simulation failed");
         $fatal(1);
      end
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/soc_ctrl_pkg.sv
hw/apb_reg_decode.sv
hw/pad_ctrl_regs.sv
hw/boot_ctrl_regs.sv
hw/jtag_mailbox.sv
hw/soc_ctrl_top.sv
dv/tb_soc_ctrl.sv

/* Makefile */
# Verilator build and run for the SoC control register block

VERILATOR ?= verilator
TOP       ?= tb_soc_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  ?= Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
